// ==== common/spriteSheet_params.svh ====
// Sprite sheet and HUD constants
`ifndef SPRITE_SHEET_PARAMS_SVH
`define SPRITE_SHEET_PARAMS_SVH

// Actor box, measured from the center
`define ACTOR_HALF_WIDTH  20
`define ACTOR_HALF_HEIGHT 30

`define SHEET_WIDTH 240   // Pixels per sheet row

// Pose columns
`define COL_IDLE   0
`define COL_MOVE   40
`define COL_ATTACK 160
`define COL_SHIELD 200
`define COL_DEAD   40

// Direction rows
`define ROW_PLAYER_RIGHT 0
`define ROW_PLAYER_LEFT  60
`define ROW_ENEMY_RIGHT  120
`define ROW_ENEMY_LEFT   180
`define ROW_DEAD         240

// Health bar in the top-left corner
`define HUD_WIDTH   50
`define HUD_HEIGHT  10
`define HEALTH_STEP 10

`define KEY_RIGHT 8'd7
`define KEY_LEFT  8'd4

`define ENEMY_COUNT  4
`define PALETTE_SIZE 20

`endif

// ==== common/spriteSheetPkg.sv ====
// Screen and sprite sheet types
`default_nettype none

package spriteSheetPkg;

    typedef logic [9:0] screenCoord_t;   // VGA pixel position

    // Actor centers live in a wider world space
    typedef logic [13:0] worldCoord_t;

    typedef logic [9:0] sheetCoord_t;    // Position inside the sheet

    // Linear address into the sheet memory, row major
    typedef logic [18:0] romAddr_t;

    typedef logic [2:0] healthLevel_t;   // Health steps shown by the HUD

endpackage

`default_nettype wire

// ==== common/vgaColorPkg.sv ====
// VGA color and palette
`default_nettype none

package vgaColorPkg;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // Same 24 bits, read whole or by channel
    typedef union packed {
        logic [23:0] word;
        rgb_t        rgb;
    } paletteWord_u;

    typedef logic [4:0] paletteIndex_t;

    // Sheet pixels in this color show the background
    localparam logic [23:0] TRANSPARENT_WORD = 24'hFFFFFF;

    // ----------------------------------------
    // Index to color
    // ----------------------------------------
    function automatic paletteWord_u paletteLookup(input paletteIndex_t index);
        paletteWord_u entry;
        case (index)
            5'd0:    entry.word = 24'hFFFFFF;
            5'd1:    entry.word = 24'h000000;
            5'd2:    entry.word = 24'h323232;
            5'd3:    entry.word = 24'h888888;
            5'd4:    entry.word = 24'h7B100C;
            5'd5:    entry.word = 24'hFF0000;
            5'd6:    entry.word = 24'hC58564;
            5'd7:    entry.word = 24'h4B1400;
            5'd8:    entry.word = 24'hBB8044;
            5'd9:    entry.word = 24'hC58F5C;
            5'd10:   entry.word = 24'hC99869;
            5'd11:   entry.word = 24'hCA6225;
            5'd12:   entry.word = 24'hC25820;
            5'd13:   entry.word = 24'hF79534;
            5'd14:   entry.word = 24'hF9953B;
            5'd15:   entry.word = 24'hFB9533;
            5'd16:   entry.word = 24'hFD9737;
            5'd17:   entry.word = 24'hF5CEA1;
            5'd18:   entry.word = 24'h80BE1F;
            5'd19:   entry.word = 24'h93DB24;
            default: entry.word = 24'h000000;   // Unused slots
        endcase
        return entry;
    endfunction

endpackage

`default_nettype wire

// ==== common/pixelBeatIf.sv ====
// Pixel context between pipeline stages
`timescale 1ns/1ps
`default_nettype none

interface pixelBeatIf;

    spriteSheetPkg::screenCoord_t beatX;
    spriteSheetPkg::screenCoord_t beatY;
    spriteSheetPkg::healthLevel_t beatHealth;
    logic                         spriteHit;   // Some actor covers the pixel

    // Address stage side
    modport source (
        output beatX, beatY, beatHealth, spriteHit
    );

    // Color stage side
    modport sink (
        input beatX, beatY, beatHealth, spriteHit
    );

endinterface

`default_nettype wire

// ==== spriteAddress/playerSprite.sv ====
// Player box and pose
`timescale 1ns/1ps
`default_nettype none
`include "spriteSheet_params.svh"

module playerSprite (
    input  spriteSheetPkg::screenCoord_t drawX,
    input  spriteSheetPkg::screenCoord_t drawY,
    input  spriteSheetPkg::worldCoord_t  playerX,
    input  spriteSheetPkg::worldCoord_t  playerY,
    input  logic                         playerRight,
    input  logic                         punch,
    input  logic                         shield,
    input  logic                         gameOver,
    input  logic                         changeFrame,
    input  logic [7:0]                   keycode,
    output logic                         hit,
    output spriteSheetPkg::sheetCoord_t  sheetX,
    output spriteSheetPkg::sheetCoord_t  sheetY
);

    localparam logic signed [14:0] HALF_W = 15'(`ACTOR_HALF_WIDTH);
    localparam logic signed [14:0] HALF_H = 15'(`ACTOR_HALF_HEIGHT);

    logic signed [14:0] distX, distY;
    logic signed [14:0] offX, offY;
    logic                        keyHeld;
    spriteSheetPkg::sheetCoord_t col, row;

    // Signed distance from the box center
    assign distX = $signed({5'b0, drawX}) - $signed({1'b0, playerX});
    assign distY = $signed({5'b0, drawY}) - $signed({1'b0, playerY});

    assign hit = (distX >= -HALF_W) && (distX <= HALF_W) &&
                 (distY >= -HALF_H) && (distY <= HALF_H);

    // Offset from the top-left corner of the box
    assign offX = distX + HALF_W;
    assign offY = distY + HALF_H;

    // Only the key matching the facing counts as walking
    assign keyHeld = playerRight ? (keycode == `KEY_RIGHT) : (keycode == `KEY_LEFT);

    always_comb
    begin
        row = playerRight ? spriteSheetPkg::sheetCoord_t'(`ROW_PLAYER_RIGHT)
                          : spriteSheetPkg::sheetCoord_t'(`ROW_PLAYER_LEFT);
        if (keyHeld)
            col = changeFrame ? spriteSheetPkg::sheetCoord_t'(`COL_MOVE)
                              : spriteSheetPkg::sheetCoord_t'(`COL_IDLE);
        else if (punch)
            col = spriteSheetPkg::sheetCoord_t'(`COL_ATTACK);
        else if (shield)
            col = spriteSheetPkg::sheetCoord_t'(`COL_SHIELD);
        else if (gameOver)
        begin
            // Dead pose sits on its own row
            col = spriteSheetPkg::sheetCoord_t'(`COL_DEAD);
            row = spriteSheetPkg::sheetCoord_t'(`ROW_DEAD);
        end
        else
            col = spriteSheetPkg::sheetCoord_t'(`COL_IDLE);
    end

    assign sheetX = col + offX[9:0];
    assign sheetY = row + offY[9:0];

endmodule

`default_nettype wire

// ==== spriteAddress/enemySprite.sv ====
// Enemy box and pose
`timescale 1ns/1ps
`default_nettype none
`include "spriteSheet_params.svh"

module enemySprite (
    input  spriteSheetPkg::screenCoord_t drawX,
    input  spriteSheetPkg::screenCoord_t drawY,
    input  spriteSheetPkg::worldCoord_t  enemyX,
    input  spriteSheetPkg::worldCoord_t  enemyY,
    input  logic                         enemyRight,
    input  logic                         attack,
    input  logic                         shieldUp,
    input  logic                         dead,
    input  logic                         changeFrame,
    output logic                         hit,
    output spriteSheetPkg::sheetCoord_t  sheetX,
    output spriteSheetPkg::sheetCoord_t  sheetY
);

    localparam logic signed [14:0] HALF_W = 15'(`ACTOR_HALF_WIDTH);
    localparam logic signed [14:0] HALF_H = 15'(`ACTOR_HALF_HEIGHT);

    logic signed [14:0] distX, distY;
    logic signed [14:0] offX, offY;
    logic                        inBox;
    spriteSheetPkg::sheetCoord_t col, row;

    assign distX = $signed({5'b0, drawX}) - $signed({1'b0, enemyX});
    assign distY = $signed({5'b0, drawY}) - $signed({1'b0, enemyY});

    assign inBox = (distX >= -HALF_W) && (distX <= HALF_W) &&
                   (distY >= -HALF_H) && (distY <= HALF_H);

    assign hit = inBox && !dead;   // Dead enemies vanish

    assign offX = distX + HALF_W;
    assign offY = distY + HALF_H;

    always_comb
    begin
        row = enemyRight ? spriteSheetPkg::sheetCoord_t'(`ROW_ENEMY_RIGHT)
                         : spriteSheetPkg::sheetCoord_t'(`ROW_ENEMY_LEFT);
        if (attack)
            col = spriteSheetPkg::sheetCoord_t'(`COL_ATTACK);
        else if (shieldUp)
            col = spriteSheetPkg::sheetCoord_t'(`COL_SHIELD);
        else if (changeFrame)
            col = spriteSheetPkg::sheetCoord_t'(`COL_MOVE);   // Walk frame two
        else
            col = spriteSheetPkg::sheetCoord_t'(`COL_IDLE);
    end

    assign sheetX = col + offX[9:0];
    assign sheetY = row + offY[9:0];

endmodule

`default_nettype wire

// ==== spriteAddress/spriteAddressGen.sv ====
// Sprite sheet address stage
`timescale 1ns/1ps
`default_nettype none
`include "spriteSheet_params.svh"

module spriteAddressGen (
    input  logic                         Clk,
    input  logic                         rstN,
    input  spriteSheetPkg::screenCoord_t drawX,
    input  spriteSheetPkg::screenCoord_t drawY,
    input  spriteSheetPkg::healthLevel_t health,
    input  logic                         playerHit,
    input  spriteSheetPkg::sheetCoord_t  playerSheetX,
    input  spriteSheetPkg::sheetCoord_t  playerSheetY,
    input  logic [`ENEMY_COUNT-1:0]      enemyHit,
    input  spriteSheetPkg::sheetCoord_t  enemySheetX [`ENEMY_COUNT],
    input  spriteSheetPkg::sheetCoord_t  enemySheetY [`ENEMY_COUNT],
    output spriteSheetPkg::romAddr_t     readAddress,
    pixelBeatIf.source                   beat
);

    logic                        winHit;
    spriteSheetPkg::sheetCoord_t winX, winY;
    spriteSheetPkg::romAddr_t    nextAddress;

    // ----------------------------------------
    // Actor priority
    // ----------------------------------------
    always_comb
    begin
        winHit = playerHit;
        winX   = playerSheetX;
        winY   = playerSheetY;
        if (!playerHit)
        begin
            winX = '0;
            winY = '0;
            // Walk down so that enemy 0 is taken last and wins
            for (int i = `ENEMY_COUNT - 1; i >= 0; i--)
            begin
                if (enemyHit[i])
                begin
                    winHit = 1'b1;
                    winX   = enemySheetX[i];
                    winY   = enemySheetY[i];
                end
            end
        end
    end

    // Row major address, zero when nothing is drawn
    assign nextAddress = winHit
        ? spriteSheetPkg::romAddr_t'(winY) * spriteSheetPkg::romAddr_t'(`SHEET_WIDTH)
          + spriteSheetPkg::romAddr_t'(winX)
        : '0;

    // ----------------------------------------
    // Stage register
    // ----------------------------------------
    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            readAddress     <= '0;
            beat.spriteHit  <= 1'b0;
            beat.beatX      <= '0;
            beat.beatY      <= '0;
            beat.beatHealth <= '0;
        end
        else
        begin
            readAddress     <= nextAddress;
            beat.spriteHit  <= winHit;
            beat.beatX      <= drawX;
            beat.beatY      <= drawY;
            beat.beatHealth <= health;
        end
    end

endmodule

`default_nettype wire

// ==== source/pixelColorizer.sv ====
// Pixel color stage
`timescale 1ns/1ps
`default_nettype none
`include "spriteSheet_params.svh"

module pixelColorizer (
    input  logic                      Clk,
    input  logic                      rstN,
    pixelBeatIf.sink                  beat,
    input  vgaColorPkg::paletteIndex_t pixelIndex,
    output logic [7:0]                vgaR,
    output logic [7:0]                vgaG,
    output logic [7:0]                vgaB
);

    spriteSheetPkg::screenCoord_t dlyX, dlyY;
    spriteSheetPkg::healthLevel_t dlyHealth;
    logic                         dlyHit;
    spriteSheetPkg::screenCoord_t healthLimit;
    vgaColorPkg::paletteWord_u    palWord;
    vgaColorPkg::rgb_t            nextColor, colorReg;
    logic                         inHud, opaque;

    // Wait out the memory read so the beat meets its pixelIndex
    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            dlyHit    <= 1'b0;
            dlyX      <= '0;
            dlyY      <= '0;
            dlyHealth <= '0;
        end
        else
        begin
            dlyHit    <= beat.spriteHit;
            dlyX      <= beat.beatX;
            dlyY      <= beat.beatY;
            dlyHealth <= beat.beatHealth;
        end
    end

    // ----------------------------------------
    // Color choice
    // ----------------------------------------
    assign palWord     = vgaColorPkg::paletteLookup(pixelIndex);
    assign opaque      = dlyHit && (palWord.word != vgaColorPkg::TRANSPARENT_WORD);
    assign healthLimit = spriteSheetPkg::screenCoord_t'(dlyHealth) *
                         spriteSheetPkg::screenCoord_t'(`HEALTH_STEP);
    assign inHud       = (dlyY <= `HUD_HEIGHT) && (dlyX <= `HUD_WIDTH);

    always_comb
    begin
        if (inHud)
        begin
            // Green up to the health mark, red after it
            if (dlyX <= healthLimit)
                nextColor = '{red: 8'h00, green: 8'hFF, blue: 8'h00};
            else
                nextColor = '{red: 8'hFF, green: 8'h00, blue: 8'h00};
        end
        else if (opaque)
            nextColor = palWord.rgb;
        else
            nextColor = '{red: 8'h00, green: 8'hBF, blue: 8'hFF - {1'b0, dlyX[9:3]}};
    end

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
            colorReg <= '0;
        else
            colorReg <= nextColor;
    end

    assign vgaR = colorReg.red;
    assign vgaG = colorReg.green;
    assign vgaB = colorReg.blue;

endmodule

`default_nettype wire

// ==== source/colorMapperTop.sv ====
// Sprite color mapper top
`timescale 1ns/1ps
`default_nettype none
`include "spriteSheet_params.svh"

module colorMapperTop (
    input  logic                         Clk,
    input  logic                         rstN,
    input  spriteSheetPkg::screenCoord_t drawX,
    input  spriteSheetPkg::screenCoord_t drawY,
    // Player state
    input  spriteSheetPkg::worldCoord_t  playerX,
    input  spriteSheetPkg::worldCoord_t  playerY,
    input  logic                         playerRight,
    input  logic [7:0]                   keycode,
    input  logic                         punch,
    input  logic                         shield,
    input  logic                         gameOver,
    input  spriteSheetPkg::healthLevel_t health,
    // Enemy state, one slot per enemy
    input  spriteSheetPkg::worldCoord_t  enemyX [`ENEMY_COUNT],
    input  spriteSheetPkg::worldCoord_t  enemyY [`ENEMY_COUNT],
    input  logic [`ENEMY_COUNT-1:0]      enemyRight,
    input  logic [`ENEMY_COUNT-1:0]      enemyAttack,
    input  logic [`ENEMY_COUNT-1:0]      enemyShield,
    input  logic [`ENEMY_COUNT-1:0]      enemyDead,
    input  logic                         changeFrame,
    // Sprite sheet memory
    output spriteSheetPkg::romAddr_t     readAddress,
    input  vgaColorPkg::paletteIndex_t   pixelIndex,
    output logic [7:0]                   vgaR,
    output logic [7:0]                   vgaG,
    output logic [7:0]                   vgaB
);

    logic                        playerHit;
    spriteSheetPkg::sheetCoord_t playerSheetX, playerSheetY;
    logic [`ENEMY_COUNT-1:0]     enemyHit;
    spriteSheetPkg::sheetCoord_t enemySheetX [`ENEMY_COUNT];
    spriteSheetPkg::sheetCoord_t enemySheetY [`ENEMY_COUNT];

    pixelBeatIf beatBus ();

    playerSprite playerSprite_inst (
        .drawX(drawX), .drawY(drawY), .playerX(playerX), .playerY(playerY),
        .playerRight(playerRight), .punch(punch), .shield(shield), .gameOver(gameOver),
        .changeFrame(changeFrame), .keycode(keycode),
        .hit(playerHit), .sheetX(playerSheetX), .sheetY(playerSheetY)
    );

    for (genvar e = 0; e < `ENEMY_COUNT; e++)
    begin : genEnemy
        enemySprite enemySprite_inst (
            .drawX(drawX), .drawY(drawY), .enemyX(enemyX[e]), .enemyY(enemyY[e]),
            .enemyRight(enemyRight[e]), .attack(enemyAttack[e]),
            .shieldUp(enemyShield[e]), .dead(enemyDead[e]), .changeFrame(changeFrame),
            .hit(enemyHit[e]), .sheetX(enemySheetX[e]), .sheetY(enemySheetY[e])
        );
    end

    spriteAddressGen spriteAddressGen_inst (
        .Clk(Clk), .rstN(rstN), .drawX(drawX), .drawY(drawY), .health(health),
        .playerHit(playerHit), .playerSheetX(playerSheetX), .playerSheetY(playerSheetY),
        .enemyHit(enemyHit), .enemySheetX(enemySheetX), .enemySheetY(enemySheetY),
        .readAddress(readAddress), .beat(beatBus.source)
    );

    pixelColorizer pixelColorizer_inst (
        .Clk(Clk), .rstN(rstN), .beat(beatBus.sink), .pixelIndex(pixelIndex),
        .vgaR(vgaR), .vgaG(vgaG), .vgaB(vgaB)
    );

endmodule

`default_nettype wire

// ==== verification/colorMapperTb.sv ====
// Color mapper testbench
`timescale 1ns/1ps
`default_nettype none
`include "spriteSheet_params.svh"

module colorMapperTb;

    localparam int DRAIN_LIMIT = 20;   // Cycles allowed for the last pixel to come out

    logic                         Clk = 1'b0;
    logic                         rstN;
    spriteSheetPkg::screenCoord_t drawX, drawY;
    spriteSheetPkg::worldCoord_t  playerX, playerY;
    logic                         playerRight, punch, shield, gameOver, changeFrame;
    logic [7:0]                   keycode;
    spriteSheetPkg::healthLevel_t health;
    spriteSheetPkg::worldCoord_t  enemyX [`ENEMY_COUNT];
    spriteSheetPkg::worldCoord_t  enemyY [`ENEMY_COUNT];
    logic [`ENEMY_COUNT-1:0]      enemyRight, enemyAttack, enemyShield, enemyDead;
    spriteSheetPkg::romAddr_t     readAddress;
    vgaColorPkg::paletteIndex_t   pixelIndex = '0;
    logic [7:0]                   vgaR, vgaG, vgaB;

    spriteSheetPkg::romAddr_t addrHist [$];   // Expected values with the newest first
    logic [23:0]              rgbHist [$];
    int sinceRelease = 0;
    int beatsChecked = 0;
    int expAddr;
    bit expHit;
    int sceneX [`ENEMY_COUNT + 1];   // Slot 0 is the player
    int sceneY [`ENEMY_COUNT + 1];

    colorMapperTop colorMapperTop_inst (
        .Clk(Clk), .rstN(rstN), .drawX(drawX), .drawY(drawY),
        .playerX(playerX), .playerY(playerY), .playerRight(playerRight),
        .keycode(keycode), .punch(punch), .shield(shield), .gameOver(gameOver),
        .health(health), .enemyX(enemyX), .enemyY(enemyY), .enemyRight(enemyRight),
        .enemyAttack(enemyAttack), .enemyShield(enemyShield), .enemyDead(enemyDead),
        .changeFrame(changeFrame), .readAddress(readAddress), .pixelIndex(pixelIndex),
        .vgaR(vgaR), .vgaG(vgaG), .vgaB(vgaB)
    );

    always #4 Clk = ~Clk;

    // Sprite sheet memory model with one cycle of read latency
    always @(posedge Clk)
        pixelIndex <= vgaColorPkg::paletteIndex_t'(readAddress % `PALETTE_SIZE);

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic void actorBox(input int cx, input int cy, output bit inBox,
                                     output int offX, output int offY);
        int dx;
        int dy;
        dx = int'(drawX) - cx;
        dy = int'(drawY) - cy;
        inBox = (dx >= -`ACTOR_HALF_WIDTH) && (dx <= `ACTOR_HALF_WIDTH) &&
                (dy >= -`ACTOR_HALF_HEIGHT) && (dy <= `ACTOR_HALF_HEIGHT);
        offX = dx + `ACTOR_HALF_WIDTH;    // From the left edge of the box
        offY = dy + `ACTOR_HALF_HEIGHT;
    endfunction

    function automatic int sheetAddress(output bit anyHit);
        bit inBox;
        bit walking;
        int offX, offY, col, row, result;
        anyHit = 1'b0;
        result = 0;
        actorBox(int'(playerX), int'(playerY), inBox, offX, offY);
        if (inBox)
        begin
            walking = playerRight ? (keycode == `KEY_RIGHT) : (keycode == `KEY_LEFT);
            row = playerRight ? `ROW_PLAYER_RIGHT : `ROW_PLAYER_LEFT;
            if (walking)
                col = changeFrame ? `COL_MOVE : `COL_IDLE;
            else if (punch)
                col = `COL_ATTACK;
            else if (shield)
                col = `COL_SHIELD;
            else if (gameOver)
            begin
                col = `COL_DEAD;
                row = `ROW_DEAD;
            end
            else
                col = `COL_IDLE;
            anyHit = 1'b1;
            result = (row + offY) * `SHEET_WIDTH + col + offX;
        end
        // Lowest enemy index wins and dead enemies are skipped
        for (int i = 0; i < `ENEMY_COUNT && !anyHit; i++)
        begin
            actorBox(int'(enemyX[i]), int'(enemyY[i]), inBox, offX, offY);
            if (inBox && !enemyDead[i])
            begin
                row = enemyRight[i] ? `ROW_ENEMY_RIGHT : `ROW_ENEMY_LEFT;
                if (enemyAttack[i])
                    col = `COL_ATTACK;
                else if (enemyShield[i])
                    col = `COL_SHIELD;
                else
                    col = changeFrame ? `COL_MOVE : `COL_IDLE;
                anyHit = 1'b1;
                result = (row + offY) * `SHEET_WIDTH + col + offX;
            end
        end
        return result;
    endfunction

    function automatic logic [23:0] screenColor(input int x, input int y, input int hp,
                                                input bit anyHit, input int addr);
        vgaColorPkg::paletteWord_u entry;
        entry = vgaColorPkg::paletteLookup(vgaColorPkg::paletteIndex_t'(addr % `PALETTE_SIZE));
        if ((y <= `HUD_HEIGHT) && (x <= `HUD_WIDTH))
            return (x <= hp * `HEALTH_STEP) ? 24'h00FF00 : 24'hFF0000;
        else if (anyHit && (entry.word != 24'hFFFFFF))
            return entry.word;
        else
            return {8'h00, 8'hBF, 8'(255 - x / 8)};   // Gradient darkens to the right
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic reportMismatch(input string name, input logic [23:0] got,
                                  input logic [23:0] want);
        abortRun($sformatf("error at %0d ns: %s is %h, expected %h",
                           $time, name, got, want));
    endtask

    // ----------------------------------------
    // Comparing process
    // ----------------------------------------
    always @(negedge Clk)
    begin
        if (!rstN)
        begin
            sinceRelease = 0;
            assert (readAddress == '0)
            else reportMismatch("readAddress", 24'(readAddress), 24'h0);
            assert ({vgaR, vgaG, vgaB} == 24'h0)
            else reportMismatch("{vgaR,vgaG,vgaB}", {vgaR, vgaG, vgaB}, 24'h0);
            // Cleared stage registers look like pixel (0, 0) with no hit
            addrHist.push_front('0);
            rgbHist.push_front(screenColor(0, 0, 0, 1'b0, 0));
        end
        else
        begin
            sinceRelease++;
            expAddr = sheetAddress(expHit);
            addrHist.push_front(spriteSheetPkg::romAddr_t'(expAddr));
            rgbHist.push_front(screenColor(int'(drawX), int'(drawY), int'(health),
                                           expHit, expAddr));
            assert (readAddress == addrHist[1])
            else reportMismatch("readAddress", 24'(readAddress), 24'(addrHist[1]));
            if (sinceRelease == 1)
            begin
                assert ({vgaR, vgaG, vgaB} == 24'h0)   // Still the reset value
                else reportMismatch("{vgaR,vgaG,vgaB}", {vgaR, vgaG, vgaB}, 24'h0);
            end
            else
            begin
                assert ({vgaR, vgaG, vgaB} == rgbHist[3])
                else reportMismatch("{vgaR,vgaG,vgaB}", {vgaR, vgaG, vgaB}, rgbHist[3]);
                if (sinceRelease > 3)
                    beatsChecked++;
            end
        end
        if (addrHist.size() > 4)
        begin
            void'(addrHist.pop_back());
            void'(rgbHist.pop_back());
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    function automatic int pickBetween(input int lo, input int hi);
        return lo + int'($urandom_range(hi - lo));
    endfunction

    task automatic applyPixel(input int x, input int y);
        @(posedge Clk);
        drawX <= spriteSheetPkg::screenCoord_t'(x);
        drawY <= spriteSheetPkg::screenCoord_t'(y);
    endtask

    task automatic placeEnemy(input int i, input int x, input int y);
        enemyX[i] <= spriteSheetPkg::worldCoord_t'(x);
        enemyY[i] <= spriteSheetPkg::worldCoord_t'(y);
    endtask

    task automatic randomizeScene();
        int pick;
        for (int a = 0; a <= `ENEMY_COUNT; a++)
        begin
            sceneX[a] = pickBetween(30, 610);
            sceneY[a] = pickBetween(40, 440);
        end
        pick = pickBetween(0, 2);
        keycode     <= (pick == 0) ? `KEY_RIGHT : ((pick == 1) ? `KEY_LEFT : 8'd0);
        playerX     <= spriteSheetPkg::worldCoord_t'(sceneX[0]);
        playerY     <= spriteSheetPkg::worldCoord_t'(sceneY[0]);
        playerRight <= 1'($urandom);
        punch       <= 1'($urandom);
        shield      <= 1'($urandom);
        gameOver    <= ($urandom_range(3) == 0);
        changeFrame <= 1'($urandom);
        health      <= 3'($urandom_range(5));
        enemyRight  <= 4'($urandom);
        enemyAttack <= 4'($urandom);
        enemyShield <= 4'($urandom);
        enemyDead   <= 4'($urandom) & 4'($urandom);   // Mostly alive
        for (int i = 0; i < `ENEMY_COUNT; i++)
            placeEnemy(i, sceneX[i + 1], sceneY[i + 1]);
    endtask

    task automatic cyclePlayerPoses();
        for (int facing = 0; facing < 2; facing++)
        begin
            for (int pose = 0; pose < 6; pose++)
            begin
                playerRight <= facing[0];
                // Poses 0 and 1 walk and pose 5 holds the key of the other side
                keycode     <= (pose < 2) ? ((facing == 1) ? `KEY_RIGHT : `KEY_LEFT)
                             : ((pose == 5) ? ((facing == 1) ? `KEY_LEFT : `KEY_RIGHT)
                                            : 8'd0);
                changeFrame <= (pose == 0);
                punch       <= (pose == 2);
                shield      <= (pose == 3);
                gameOver    <= (pose == 4);
                for (int n = 0; n < 12; n++)
                    applyPixel(pickBetween(78, 122), pickBetween(68, 132));
            end
        end
    endtask

    task automatic stackEnemies();
        keycode  <= 8'd0;
        punch    <= 1'b0;
        shield   <= 1'b0;
        gameOver <= 1'b0;
        playerY  <= 14'd200;
        for (int i = 0; i < `ENEMY_COUNT; i++)
            placeEnemy(i, 210 + 10 * i, 195 + 8 * i);   // Overlapping boxes
        for (int k = 0; k < 32; k++)
        begin
            playerX     <= k[4] ? 14'd200 : 14'd5000;
            enemyDead   <= k[3:0];
            enemyAttack <= 4'($urandom);
            enemyShield <= 4'($urandom);
            enemyRight  <= 4'($urandom);
            changeFrame <= k[0];
            for (int n = 0; n < 8; n++)
                applyPixel(pickBetween(170, 280), pickBetween(160, 260));
        end
    endtask

    task automatic scatterSpritePixels();
        int actor;
        for (int k = 0; k < 40; k++)
        begin
            randomizeScene();
            for (int n = 0; n < 8; n++)
            begin
                actor = pickBetween(0, `ENEMY_COUNT);
                applyPixel(sceneX[actor] + pickBetween(-24, 24),
                           sceneY[actor] + pickBetween(-34, 34));
            end
        end
    endtask

    task automatic sweepHudBar();
        playerX  <= 14'd25;    // Sprite under the HUD corner
        playerY  <= 14'd5;
        gameOver <= 1'b0;
        for (int hp = 0; hp <= 5; hp++)
        begin
            health <= 3'(hp);
            for (int x = 0; x <= `HUD_WIDTH + 1; x++)
                applyPixel(x, pickBetween(0, `HUD_HEIGHT + 1));
        end
    endtask

    task automatic streamRandomPixels();
        for (int k = 0; k < 10; k++)
        begin
            randomizeScene();
            for (int n = 0; n < 50; n++)
                applyPixel(pickBetween(0, 639), pickBetween(0, 479));
        end
    endtask

    task automatic drainPipeline();
        int target;
        int waited;
        target = sinceRelease + 1;   // Last pixel is logged at the coming negedge
        waited = 0;
        while (beatsChecked < target && waited < DRAIN_LIMIT)
        begin
            @(posedge Clk);
            waited++;
        end
        if (beatsChecked < target)
            abortRun("timeout: the last pixels never reached the color output");
    endtask

    initial
    begin
        void'($urandom(66516));
        rstN        <= 1'b0;
        drawX       <= '0;
        drawY       <= '0;
        playerX     <= 14'd100;
        playerY     <= 14'd100;
        playerRight <= 1'b1;
        keycode     <= 8'd0;
        punch       <= 1'b0;
        shield      <= 1'b0;
        gameOver    <= 1'b0;
        changeFrame <= 1'b0;
        health      <= '0;
        enemyRight  <= '0;
        enemyAttack <= '0;
        enemyShield <= '0;
        enemyDead   <= '0;
        for (int i = 0; i < `ENEMY_COUNT; i++)
            placeEnemy(i, 5000, 5000);   // Off screen until needed
        repeat (8) @(posedge Clk);
        rstN <= 1'b1;
        cyclePlayerPoses();
        stackEnemies();
        scatterSpritePixels();
        sweepHudBar();
        streamRandomPixels();
        drainPipeline();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+common
common/spriteSheetPkg.sv
common/vgaColorPkg.sv
common/pixelBeatIf.sv
spriteAddress/playerSprite.sv
spriteAddress/enemySprite.sv
spriteAddress/spriteAddressGen.sv
source/pixelColorizer.sv
source/colorMapperTop.sv
verification/colorMapperTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the color mapper testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f \
    --top-module colorMapperTb \
    -o colorMapperSim &&
./obj_dir/colorMapperSim ||
{
    echo "Simulation failed" >&2
    exit 1
}
